//--- design/lstm_cfg_pkg.sv
`default_nettype none

package lstm_cfg_pkg;

    // Problem dimensions
    localparam int VEC_LEN   = 8;
    localparam int HIDDEN    = 4;
    localparam int TILE      = 4;
    localparam int NUM_GATES = 4;
    localparam int NUM_ROWS  = NUM_GATES * HIDDEN;
    localparam int COL_TILES = VEC_LEN / TILE;

    // Field widths inside a host weight address
    localparam int COL_BITS  = $clog2(VEC_LEN);
    localparam int LANE_BITS = $clog2(TILE);

    // Entries per lane bank, one row of every row group
    localparam int LANE_DEPTH = (NUM_ROWS / TILE) * VEC_LEN;

    typedef logic [COL_BITS-1:0] vec_addr_t;

    // Host weight address, row * VEC_LEN + column
    typedef logic [6:0] w_addr_t;

    // Row group * VEC_LEN + column
    typedef logic [4:0] lane_addr_t;

    typedef logic [1:0] hid_idx_t;

    // Row group index equals the gate value
    typedef enum logic [1:0] {
        GATE_FORGET = 2'd0,
        GATE_INPUT  = 2'd1,
        GATE_CAND   = 2'd2,
        GATE_OUTPUT = 2'd3
    } gate_e;

    typedef enum logic [1:0] {
        SEQ_IDLE   = 2'd0,
        SEQ_MAC    = 2'd1,
        SEQ_UPDATE = 2'd2
    } seq_state_e;

endpackage

`default_nettype wire

//--- design/lstm_fixed_pkg.sv
`default_nettype none

package lstm_fixed_pkg;

    localparam int FRAC_BITS = 8;

    // Q8.8 data, Q16.16 accumulator
    typedef logic signed [15:0] data_t;
    typedef logic signed [31:0] acc_t;

    localparam data_t ONE_Q    = 16'sd256;
    localparam data_t DATA_MAX = 16'sh7fff;
    localparam data_t DATA_MIN = 16'sh8000;

    // Q16.16 product sum back to Q8.8 with saturation
    function automatic data_t sat_shift(input acc_t value);
        acc_t shifted;
        shifted = value >>> FRAC_BITS;
        if (shifted > acc_t'(DATA_MAX)) begin
            return DATA_MAX;
        end
        if (shifted < acc_t'(DATA_MIN)) begin
            return DATA_MIN;
        end
        return data_t'(shifted);
    endfunction

    // Slope 1/4 around one half, clamped to 0..1
    function automatic data_t hard_sigmoid(input data_t x);
        acc_t lin;
        lin = acc_t'(x >>> 2) + acc_t'(ONE_Q >>> 1);
        if (lin > acc_t'(ONE_Q)) begin
            return ONE_Q;
        end
        if (lin < 0) begin
            return '0;
        end
        return data_t'(lin);
    endfunction

    function automatic data_t hard_tanh(input data_t x);
        if (x > ONE_Q) begin
            return ONE_Q;
        end
        if (x < -ONE_Q) begin
            return -ONE_Q;
        end
        return x;
    endfunction

endpackage

`default_nettype wire

//--- design/vector_weight_store.sv
`timescale 1ns/1ps
`default_nettype none

module vector_weight_store (
    input  wire logic                      clk,
    input  wire logic                      vec_we,
    input  wire lstm_cfg_pkg::vec_addr_t   vec_addr,
    input  wire logic                      w_we,
    input  wire lstm_cfg_pkg::w_addr_t     w_addr,
    input  wire lstm_fixed_pkg::data_t     wr_data,
    input  wire lstm_cfg_pkg::vec_addr_t   rd_col,
    input  wire lstm_cfg_pkg::lane_addr_t  rd_lane_addr,
    output lstm_fixed_pkg::data_t          rd_vec,
    output lstm_fixed_pkg::data_t          w_lane0,
    output lstm_fixed_pkg::data_t          w_lane1,
    output lstm_fixed_pkg::data_t          w_lane2,
    output lstm_fixed_pkg::data_t          w_lane3
);
    import lstm_cfg_pkg::*;
    import lstm_fixed_pkg::*;

    data_t vec_mem [VEC_LEN];

    // Row r of the matrix lives in bank r mod TILE
    data_t w_mem [TILE][LANE_DEPTH];

    logic [LANE_BITS-1:0] wr_lane;
    lane_addr_t           wr_lane_addr;

    // Row bits above the lane select give the row group
    assign wr_lane      = w_addr[COL_BITS +: LANE_BITS];
    assign wr_lane_addr = {w_addr[$bits(w_addr_t)-1 : COL_BITS+LANE_BITS],
                           w_addr[COL_BITS-1:0]};

    always_ff @(posedge clk) begin
        if (vec_we) begin
            vec_mem[vec_addr] <= wr_data;
        end
        if (w_we) begin
            w_mem[wr_lane][wr_lane_addr] <= wr_data;
        end
    end

    // All four lanes and the vector element read in parallel
    always_ff @(posedge clk) begin
        rd_vec  <= vec_mem[rd_col];
        w_lane0 <= w_mem[0][rd_lane_addr];
        w_lane1 <= w_mem[1][rd_lane_addr];
        w_lane2 <= w_mem[2][rd_lane_addr];
        w_lane3 <= w_mem[3][rd_lane_addr];
    end

endmodule

`default_nettype wire

//--- design/tile_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module tile_sequencer (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      start,
    input  wire logic                      upd_done,
    output logic                           busy,
    output lstm_cfg_pkg::vec_addr_t        rd_col,
    output lstm_cfg_pkg::lane_addr_t       rd_lane_addr,
    output logic                           mac_en,
    output logic                           mac_clear_first,
    output logic                           group_last,
    output logic                           upd_start
);
    import lstm_cfg_pkg::*;

    seq_state_e state;

    logic [$clog2(NUM_GATES)-1:0] grp_cnt;
    logic [$clog2(COL_TILES)-1:0] tile_cnt;
    logic [LANE_BITS-1:0]         col_cnt;

    logic first_col;
    logic last_col;
    logic last_grp;

    assign first_col = (tile_cnt == '0) && (col_cnt == '0);
    assign last_col  = (tile_cnt == COL_TILES - 1) && (col_cnt == TILE - 1);
    assign last_grp  = (grp_cnt == NUM_GATES - 1);

    // Tile and column counters form the vector index
    assign rd_col       = {tile_cnt, col_cnt};
    assign rd_lane_addr = {grp_cnt, tile_cnt, col_cnt};

    assign busy = (state != SEQ_IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state           <= SEQ_IDLE;
            grp_cnt         <= '0;
            tile_cnt        <= '0;
            col_cnt         <= '0;
            mac_en          <= 1'b0;
            mac_clear_first <= 1'b0;
            group_last      <= 1'b0;
            upd_start       <= 1'b0;
        end else begin
            // MAC strobes trail the read address by the store latency
            mac_en          <= (state == SEQ_MAC);
            mac_clear_first <= (state == SEQ_MAC) && first_col;
            group_last      <= (state == SEQ_MAC) && last_col;

            // Last group reaches the gate buffers one cycle after this
            upd_start <= (state == SEQ_UPDATE) && group_last;

            case (state)
                SEQ_IDLE: begin
                    if (start) begin
                        state <= SEQ_MAC;
                    end
                end
                SEQ_MAC: begin
                    col_cnt <= col_cnt + 1'b1;
                    if (col_cnt == TILE - 1) begin
                        tile_cnt <= tile_cnt + 1'b1;
                        if (last_col) begin
                            grp_cnt <= grp_cnt + 1'b1;
                            if (last_grp) begin
                                state <= SEQ_UPDATE;
                            end
                        end
                    end
                end
                SEQ_UPDATE: begin
                    if (upd_done) begin
                        state <= SEQ_IDLE;
                    end
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/tile_mac_array.sv
`timescale 1ns/1ps
`default_nettype none

module tile_mac_array (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      mac_en,
    input  wire logic                      mac_clear_first,
    input  wire logic                      group_last,
    input  wire lstm_fixed_pkg::data_t     rd_vec,
    input  wire lstm_fixed_pkg::data_t     w_lane0,
    input  wire lstm_fixed_pkg::data_t     w_lane1,
    input  wire lstm_fixed_pkg::data_t     w_lane2,
    input  wire lstm_fixed_pkg::data_t     w_lane3,
    output logic                           group_valid,
    output lstm_cfg_pkg::gate_e            group_gate,
    output lstm_fixed_pkg::data_t          sum0,
    output lstm_fixed_pkg::data_t          sum1,
    output lstm_fixed_pkg::data_t          sum2,
    output lstm_fixed_pkg::data_t          sum3
);
    import lstm_cfg_pkg::*;
    import lstm_fixed_pkg::*;

    data_t w_in    [TILE];
    acc_t  acc     [TILE];
    acc_t  acc_nxt [TILE];
    data_t sum_q   [TILE];

    logic [$clog2(NUM_GATES)-1:0] grp_cnt;

    assign w_in[0] = w_lane0;
    assign w_in[1] = w_lane1;
    assign w_in[2] = w_lane2;
    assign w_in[3] = w_lane3;

    // First column of a group loads, the rest add
    always_comb begin
        for (int l = 0; l < TILE; l++) begin
            acc_nxt[l] = (mac_clear_first ? acc_t'(0) : acc[l])
                       + acc_t'(rd_vec) * acc_t'(w_in[l]);
        end
    end

    always_ff @(posedge clk) begin
        if (mac_en) begin
            for (int l = 0; l < TILE; l++) begin
                acc[l] <= acc_nxt[l];
                if (group_last) begin
                    sum_q[l] <= sat_shift(acc_nxt[l]);
                end
            end
        end
    end

    // Groups arrive in gate order
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            group_valid <= 1'b0;
            group_gate  <= GATE_FORGET;
            grp_cnt     <= '0;
        end else begin
            group_valid <= mac_en && group_last;
            if (mac_en && group_last) begin
                group_gate <= gate_e'(grp_cnt);
                grp_cnt    <= grp_cnt + 1'b1;
            end
        end
    end

    assign sum0 = sum_q[0];
    assign sum1 = sum_q[1];
    assign sum2 = sum_q[2];
    assign sum3 = sum_q[3];

endmodule

`default_nettype wire

//--- design/gate_activation.sv
`timescale 1ns/1ps
`default_nettype none

module gate_activation (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      group_valid,
    input  wire lstm_cfg_pkg::gate_e       group_gate,
    input  wire lstm_fixed_pkg::data_t     sum0,
    input  wire lstm_fixed_pkg::data_t     sum1,
    input  wire lstm_fixed_pkg::data_t     sum2,
    input  wire lstm_fixed_pkg::data_t     sum3,
    input  wire lstm_cfg_pkg::hid_idx_t    rd_idx,
    output lstm_fixed_pkg::data_t          f_val,
    output lstm_fixed_pkg::data_t          i_val,
    output lstm_fixed_pkg::data_t          g_val,
    output lstm_fixed_pkg::data_t          o_val
);
    import lstm_cfg_pkg::*;
    import lstm_fixed_pkg::*;

    data_t sum_in [HIDDEN];
    data_t act    [HIDDEN];

    // One buffer per gate, indexed by hidden element
    data_t gate_buf [NUM_GATES][HIDDEN];

    assign sum_in[0] = sum0;
    assign sum_in[1] = sum1;
    assign sum_in[2] = sum2;
    assign sum_in[3] = sum3;

    // Candidate gate uses tanh, the others sigmoid
    always_comb begin
        for (int l = 0; l < HIDDEN; l++) begin
            if (group_gate == GATE_CAND) begin
                act[l] = hard_tanh(sum_in[l]);
            end else begin
                act[l] = hard_sigmoid(sum_in[l]);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int g = 0; g < NUM_GATES; g++) begin
                for (int l = 0; l < HIDDEN; l++) begin
                    gate_buf[g][l] <= '0;
                end
            end
        end else if (group_valid) begin
            for (int l = 0; l < HIDDEN; l++) begin
                gate_buf[group_gate][l] <= act[l];
            end
        end
    end

    assign f_val = gate_buf[GATE_FORGET][rd_idx];
    assign i_val = gate_buf[GATE_INPUT][rd_idx];
    assign g_val = gate_buf[GATE_CAND][rd_idx];
    assign o_val = gate_buf[GATE_OUTPUT][rd_idx];

endmodule

`default_nettype wire

//--- design/cell_update.sv
`timescale 1ns/1ps
`default_nettype none

module cell_update (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      upd_start,
    input  wire lstm_fixed_pkg::data_t     f_val,
    input  wire lstm_fixed_pkg::data_t     i_val,
    input  wire lstm_fixed_pkg::data_t     g_val,
    input  wire lstm_fixed_pkg::data_t     o_val,
    output lstm_cfg_pkg::hid_idx_t         rd_idx,
    output lstm_fixed_pkg::data_t          ht_output,
    output logic                           ht_valid,
    output logic                           upd_done
);
    import lstm_cfg_pkg::*;
    import lstm_fixed_pkg::*;

    // c(t-1), carried from one step to the next
    data_t c_mem [HIDDEN];

    logic  active;
    logic  last_elem;
    acc_t  c_sum;
    data_t c_new;
    acc_t  h_prod;

    assign last_elem = (rd_idx == HIDDEN - 1);

    // c = f*c_prev + i*g, h = o*tanh(c)
    always_comb begin
        c_sum  = acc_t'(f_val) * acc_t'(c_mem[rd_idx])
               + acc_t'(i_val) * acc_t'(g_val);
        c_new  = sat_shift(c_sum);
        h_prod = acc_t'(o_val) * acc_t'(hard_tanh(c_new));
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active   <= 1'b0;
            rd_idx   <= '0;
            ht_valid <= 1'b0;
            upd_done <= 1'b0;
            for (int k = 0; k < HIDDEN; k++) begin
                c_mem[k] <= '0;
            end
        end else begin
            ht_valid <= active;
            upd_done <= active && last_elem;
            if (upd_start) begin
                active <= 1'b1;
                rd_idx <= '0;
            end else if (active) begin
                c_mem[rd_idx] <= c_new;
                rd_idx        <= rd_idx + 1'b1;
                if (last_elem) begin
                    active <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (active) begin
            ht_output <= sat_shift(h_prod);
        end
    end

endmodule

`default_nettype wire

//--- design/lstm_cell_top.sv
`timescale 1ns/1ps
`default_nettype none

module lstm_cell_top (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      vec_we,
    input  wire lstm_cfg_pkg::vec_addr_t   vec_addr,
    input  wire logic                      w_we,
    input  wire lstm_cfg_pkg::w_addr_t     w_addr,
    input  wire lstm_fixed_pkg::data_t     wr_data,
    input  wire logic                      start,
    output wire logic                      busy,
    output wire lstm_fixed_pkg::data_t     ht_output,
    output wire logic                      ht_valid,
    output wire logic                      done
);
    import lstm_cfg_pkg::*;
    import lstm_fixed_pkg::*;

    vec_addr_t  rd_col;
    lane_addr_t rd_lane_addr;
    data_t      rd_vec;
    data_t      w_lane0, w_lane1, w_lane2, w_lane3;

    logic       mac_en, mac_clear_first, group_last;
    logic       upd_start;

    logic       group_valid;
    gate_e      group_gate;
    data_t      sum0, sum1, sum2, sum3;

    hid_idx_t   rd_idx;
    data_t      f_val, i_val, g_val, o_val;

    vector_weight_store u_store (
        .clk(clk), .vec_we(vec_we), .vec_addr(vec_addr),
        .w_we(w_we), .w_addr(w_addr), .wr_data(wr_data),
        .rd_col(rd_col), .rd_lane_addr(rd_lane_addr), .rd_vec(rd_vec),
        .w_lane0(w_lane0), .w_lane1(w_lane1), .w_lane2(w_lane2), .w_lane3(w_lane3)
    );

    // The update's last element doubles as the step done
    tile_sequencer u_seq (
        .clk(clk), .rst_n(rst_n), .start(start), .upd_done(done),
        .busy(busy), .rd_col(rd_col), .rd_lane_addr(rd_lane_addr),
        .mac_en(mac_en), .mac_clear_first(mac_clear_first),
        .group_last(group_last), .upd_start(upd_start)
    );

    tile_mac_array u_mac (
        .clk(clk), .rst_n(rst_n), .mac_en(mac_en),
        .mac_clear_first(mac_clear_first), .group_last(group_last), .rd_vec(rd_vec),
        .w_lane0(w_lane0), .w_lane1(w_lane1), .w_lane2(w_lane2), .w_lane3(w_lane3),
        .group_valid(group_valid), .group_gate(group_gate),
        .sum0(sum0), .sum1(sum1), .sum2(sum2), .sum3(sum3)
    );

    gate_activation u_act (
        .clk(clk), .rst_n(rst_n), .group_valid(group_valid), .group_gate(group_gate),
        .sum0(sum0), .sum1(sum1), .sum2(sum2), .sum3(sum3), .rd_idx(rd_idx),
        .f_val(f_val), .i_val(i_val), .g_val(g_val), .o_val(o_val)
    );

    cell_update u_cell (
        .clk(clk), .rst_n(rst_n), .upd_start(upd_start),
        .f_val(f_val), .i_val(i_val), .g_val(g_val), .o_val(o_val),
        .rd_idx(rd_idx), .ht_output(ht_output), .ht_valid(ht_valid), .upd_done(done)
    );

endmodule

`default_nettype wire

//--- sim/tb_lstm_cell.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lstm_cell;
    import lstm_cfg_pkg::*;
    import lstm_fixed_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int NUM_TESTS   = 5;
    localparam int TEST_CYCLES = 200;

    logic      clk;
    logic      rst_n;
    logic      vec_we;
    vec_addr_t vec_addr;
    logic      w_we;
    w_addr_t   w_addr;
    data_t     wr_data;
    logic      start;
    logic      busy;
    data_t     ht_output;
    logic      ht_valid;
    logic      done;

    // Host-side copies of what is loaded into the DUT
    data_t vec_q [VEC_LEN];
    data_t w_q   [NUM_ROWS][VEC_LEN];

    // Reference cell state and expected hidden outputs
    int    c_model [HIDDEN];
    int    exp_h   [HIDDEN];
    data_t h_seen  [HIDDEN];

    int err_count;
    int tests_failed;

    lstm_cell_top u_dut (
        .clk(clk), .rst_n(rst_n), .vec_we(vec_we), .vec_addr(vec_addr),
        .w_we(w_we), .w_addr(w_addr), .wr_data(wr_data), .start(start),
        .busy(busy), .ht_output(ht_output), .ht_valid(ht_valid), .done(done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", NUM_TESTS * TEST_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    task automatic check_value(input string name, input logic [15:0] actual,
                               input logic [15:0] expected);
        if (actual !== expected) begin
            $display("error: %s is 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
            err_count++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, err_count - errs_before);
            tests_failed++;
        end
    endtask

    // Q16.16 to Q8.8 with saturation
    function automatic int sat_q(input int v);
        int s;
        s = v >>> FRAC_BITS;
        if (s > 32767) return 32767;
        if (s < -32768) return -32768;
        return s;
    endfunction

    function automatic int sig_model(input int x);
        int lin;
        lin = (x >>> 2) + 128;
        if (lin > 256) return 256;
        if (lin < 0) return 0;
        return lin;
    endfunction

    function automatic int tanh_model(input int x);
        if (x > 256) return 256;
        if (x < -256) return -256;
        return x;
    endfunction

    function automatic data_t rand_q(input int span);
        return data_t'(int'($urandom_range(2 * span)) - span);
    endfunction

    // Row r holds gate r / HIDDEN, element r % HIDDEN
    task automatic model_step;
        int acc;
        int act [NUM_ROWS];
        int c_new;
        for (int r = 0; r < NUM_ROWS; r++) begin
            acc = 0;
            for (int c = 0; c < VEC_LEN; c++) begin
                acc += int'(vec_q[c]) * int'(w_q[r][c]);
            end
            if (r / HIDDEN == int'(GATE_CAND)) begin
                act[r] = tanh_model(sat_q(acc));
            end else begin
                act[r] = sig_model(sat_q(acc));
            end
        end
        for (int k = 0; k < HIDDEN; k++) begin
            c_new = sat_q(act[k] * c_model[k] + act[HIDDEN + k] * act[2 * HIDDEN + k]);
            exp_h[k] = sat_q(act[3 * HIDDEN + k] * tanh_model(c_new));
            c_model[k] = c_new;
        end
    endtask

    task automatic load_vector;
        for (int c = 0; c < VEC_LEN; c++) begin
            @(posedge clk);
            #1;
            vec_we   = 1'b1;
            vec_addr = vec_addr_t'(c);
            wr_data  = vec_q[c];
        end
        @(posedge clk);
        #1;
        vec_we = 1'b0;
    endtask

    task automatic load_weights;
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int c = 0; c < VEC_LEN; c++) begin
                @(posedge clk);
                #1;
                w_we    = 1'b1;
                w_addr  = w_addr_t'(r * VEC_LEN + c);
                wr_data = w_q[r][c];
            end
        end
        @(posedge clk);
        #1;
        w_we = 1'b0;
    endtask

    // One accepted start, optionally a second start pulse while busy
    task automatic run_step(input int inject_at);
        int got_cnt;
        int done_cnt;
        int done_cyc;
        int cyc;
        model_step();
        @(posedge clk);
        #1;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        check_value("busy", busy, 1'b1);
        got_cnt  = 0;
        done_cnt = 0;
        done_cyc = -1;
        cyc      = 0;
        while (busy && cyc < TEST_CYCLES) begin
            @(posedge clk);
            #1;
            cyc++;
            start = (cyc == inject_at);
            if (ht_valid) begin
                if (got_cnt < HIDDEN) begin
                    check_value("ht_output", ht_output, exp_h[got_cnt]);
                    check_value("done", done, got_cnt == HIDDEN - 1);
                    h_seen[got_cnt] = ht_output;
                end
                got_cnt++;
            end
            if (done) begin
                done_cnt++;
                done_cyc = cyc;
            end
        end
        start = 1'b0;
        if (busy) begin
            $display("step did not finish within %0d cycles", TEST_CYCLES);
            err_count++;
        end
        check_value("ht_valid count", got_cnt, HIDDEN);
        check_value("done count", done_cnt, 1);
        check_value("busy fall after done", cyc - done_cyc, 1);
        // Nothing more may come out of a finished step
        repeat (6) begin
            @(posedge clk);
            #1;
            if (busy || ht_valid || done) begin
                $display("output activity after the step ended at %0t", $time);
                err_count++;
            end
        end
    endtask

    task automatic test_idle;
        int errs_before;
        errs_before = err_count;
        for (int n = 0; n < 10; n++) begin
            check_value("busy", busy, 1'b0);
            check_value("ht_valid", ht_valid, 1'b0);
            check_value("done", done, 1'b0);
            @(posedge clk);
            #1;
        end
        finish_test("idle after reset", errs_before);
    endtask

    task automatic test_identity;
        int errs_before;
        logic [15:0] hand_h [HIDDEN];
        errs_before = err_count;
        // With c(t-1) zero these follow from the gate rules by hand
        hand_h = '{16'h0100, 16'h0020, 16'h0000, 16'h0100};
        vec_q  = '{16'sh0100, 16'sh0080, -16'sh0100, 16'sh0300,
                   16'sh0200, 16'sh0000, -16'sh0200, 16'sh0400};
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int c = 0; c < VEC_LEN; c++) begin
                w_q[r][c] = (c == r % VEC_LEN) ? ONE_Q : data_t'(0);
            end
        end
        load_weights();
        load_vector();
        run_step(-1);
        for (int k = 0; k < HIDDEN; k++) begin
            check_value("ht_output hand value", h_seen[k], hand_h[k]);
        end
        finish_test("identity weights", errs_before);
    endtask

    task automatic test_random;
        int errs_before;
        errs_before = err_count;
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int c = 0; c < VEC_LEN; c++) begin
                w_q[r][c] = rand_q(256);
            end
        end
        for (int c = 0; c < VEC_LEN; c++) begin
            vec_q[c] = rand_q(512);
        end
        load_weights();
        load_vector();
        run_step(-1);
        finish_test("random small values", errs_before);
    endtask

    task automatic test_saturation;
        int errs_before;
        int mag;
        errs_before = err_count;
        // Even rows run to the positive limit, odd rows to the negative one
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int c = 0; c < VEC_LEN; c++) begin
                mag = 4096 + int'($urandom_range(4095));
                w_q[r][c] = data_t'((r % 2 == 0) ? mag : -mag);
            end
        end
        for (int c = 0; c < VEC_LEN; c++) begin
            vec_q[c] = data_t'(2048 + int'($urandom_range(255)));
        end
        load_weights();
        load_vector();
        run_step(-1);
        finish_test("saturation and clamps", errs_before);
    endtask

    task automatic test_two_steps;
        int errs_before;
        errs_before = err_count;
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int c = 0; c < VEC_LEN; c++) begin
                w_q[r][c] = rand_q(256);
            end
        end
        for (int c = 0; c < VEC_LEN; c++) begin
            vec_q[c] = rand_q(512);
        end
        load_weights();
        load_vector();
        run_step(-1);
        for (int c = 0; c < VEC_LEN; c++) begin
            vec_q[c] = rand_q(512);
        end
        load_vector();
        // Second step gets an extra start during the MAC phase
        run_step(10);
        finish_test("two steps with carried state", errs_before);
    endtask

    initial begin
        int seed_out;
        rst_n    = 1'b0;
        vec_we   = 1'b0;
        vec_addr = '0;
        w_we     = 1'b0;
        w_addr   = '0;
        wr_data  = '0;
        start    = 1'b0;
        seed_out = $urandom(39);
        err_count    = 0;
        tests_failed = 0;
        for (int k = 0; k < HIDDEN; k++) begin
            c_model[k] = 0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_idle();
        test_identity();
        test_random();
        test_saturation();
        test_two_steps();

        $display("tests run: %0d, tests failed: %0d, check errors: %0d",
                 NUM_TESTS, tests_failed, err_count);
        if (err_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
design/lstm_cfg_pkg.sv
design/lstm_fixed_pkg.sv
design/vector_weight_store.sv
design/tile_sequencer.sv
design/tile_mac_array.sv
design/gate_activation.sv
design/cell_update.sv
design/lstm_cell_top.sv
sim/tb_lstm_cell.sv
